// File: logic/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int CSR_DATA_W = 32;
    localparam int CSR_NUM_W  = 14;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam int HW_INT_W   = 8;
    localparam int INT_W      = 13;

    // estat.is / ecfg.lie layout
    localparam int SW_INT_W      = 2;
    localparam int HW_INT_LSB    = 2;
    localparam int INT_RSVD_BIT  = 10;
    localparam int TIMER_INT_BIT = 11;
    localparam int IPI_INT_BIT   = 12;

    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ESUBCODE_LSB = 22;

    // crmd keeps plv, ie, da, pg, datf, datm
    localparam int CRMD_W      = 9;
    localparam int CRMD_IE_BIT = 2;
    // prmd mirrors the plv/ie part of crmd
    localparam int PRMD_W      = 3;
    localparam int EENTRY_LSB  = 6;

    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TCFG_INITVAL_LSB  = 2;
    localparam int TICLR_CLR_BIT     = 0;

    localparam logic [CSR_DATA_W-1:0] TIMER_IDLE = '1;
    // da set, everything else zero
    localparam logic [CSR_DATA_W-1:0] CRMD_RESET = 32'h0000_0008;

    typedef enum logic [CSR_NUM_W-1:0] {
        CRMD   = 14'h00,
        PRMD   = 14'h01,
        ECFG   = 14'h04,
        ESTAT  = 14'h05,
        ERA    = 14'h06,
        BADV   = 14'h07,
        EENTRY = 14'h0c,
        SAVE0  = 14'h30,
        SAVE1  = 14'h31,
        SAVE2  = 14'h32,
        SAVE3  = 14'h33,
        TID    = 14'h40,
        TCFG   = 14'h41,
        TVAL   = 14'h42,
        TICLR  = 14'h44
    } csr_num_e;

    typedef enum logic [ECODE_W-1:0] {
        INT = 6'h00,
        ADE = 6'h08,
        ALE = 6'h09,
        SYS = 6'h0b,
        BRK = 6'h0c,
        INE = 6'h0d
    } ecode_e;

    function automatic logic [CSR_DATA_W-1:0] masked_write(
        input logic [CSR_DATA_W-1:0] old_value,
        input logic [CSR_DATA_W-1:0] mask,
        input logic [CSR_DATA_W-1:0] value
    );
        return (mask & value) | (~mask & old_value);
    endfunction

endpackage

`default_nettype wire

// File: logic/csr_exception_regs.sv
`timescale 1ns/1ns
`default_nettype none

module csr_exception_regs
    import csr_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic [CSR_NUM_W-1:0]  csr_num,
    input  wire logic                  csr_we,
    input  wire logic [CSR_DATA_W-1:0] csr_wmask,
    input  wire logic [CSR_DATA_W-1:0] csr_wvalue,
    input  wire logic                  wb_ex,
    input  wire logic [ECODE_W-1:0]    wb_ecode,
    input  wire logic [ESUBCODE_W-1:0] wb_esubcode,
    input  wire logic [CSR_DATA_W-1:0] wb_pc,
    input  wire logic [CSR_DATA_W-1:0] wb_vaddr,
    input  wire logic                  ertn_flush,
    output logic      [CSR_DATA_W-1:0] rvalue,
    output logic      [CSR_DATA_W-1:0] crmd,
    output logic      [CSR_DATA_W-1:0] eentry,
    output logic                       crmd_ie
);

    logic [CRMD_W-1:0]                crmd_q;
    logic [PRMD_W-1:0]                prmd_q;
    logic [CSR_DATA_W-1:0]            era_q;
    logic [CSR_DATA_W-1:0]            badv_q;
    logic [CSR_DATA_W-EENTRY_LSB-1:0] eentry_va;
    logic [CSR_DATA_W-1:0]            save_q [4];

    logic [CSR_DATA_W-1:0] prmd;
    logic [CSR_DATA_W-1:0] crmd_wr;
    logic [CSR_DATA_W-1:0] prmd_wr;
    logic [CSR_DATA_W-1:0] era_wr;
    logic [CSR_DATA_W-1:0] badv_wr;
    logic [CSR_DATA_W-1:0] eentry_wr;
    logic [CSR_DATA_W-1:0] save_wr;
    logic                  is_save;
    logic                  addr_err;

    assign crmd    = {{(CSR_DATA_W-CRMD_W){1'b0}}, crmd_q};
    assign prmd    = {{(CSR_DATA_W-PRMD_W){1'b0}}, prmd_q};
    assign eentry  = {eentry_va, {EENTRY_LSB{1'b0}}};
    assign crmd_ie = crmd_q[CRMD_IE_BIT];

    assign is_save = (csr_num >= SAVE0) && (csr_num <= SAVE3);

    assign crmd_wr   = masked_write(crmd, csr_wmask, csr_wvalue);
    assign prmd_wr   = masked_write(prmd, csr_wmask, csr_wvalue);
    assign era_wr    = masked_write(era_q, csr_wmask, csr_wvalue);
    assign badv_wr   = masked_write(badv_q, csr_wmask, csr_wvalue);
    assign eentry_wr = masked_write(eentry, csr_wmask, csr_wvalue);
    assign save_wr   = masked_write(save_q[csr_num[1:0]], csr_wmask, csr_wvalue);

    // ADE counts only for the fetch subcode
    assign addr_err = (wb_ecode == ADE && wb_esubcode == '0) || (wb_ecode == ALE);

    // da/pg/datf/datm take the write even while plv/ie are overridden
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            crmd_q <= CRMD_RESET[CRMD_W-1:0];
        end
        else
        begin
            if (csr_we && csr_num == CRMD)
                crmd_q <= crmd_wr[CRMD_W-1:0];
            if (wb_ex)
                crmd_q[CRMD_IE_BIT:0] <= '0;
            else if (ertn_flush)
                crmd_q[CRMD_IE_BIT:0] <= prmd_q;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wb_ex)
            prmd_q <= crmd_q[CRMD_IE_BIT:0];
        else if (csr_we && csr_num == PRMD)
            prmd_q <= prmd_wr[PRMD_W-1:0];
    end

    always_ff @(posedge clk)
    begin
        if (wb_ex)
            era_q <= wb_pc;
        else if (csr_we && csr_num == ERA)
            era_q <= era_wr;
    end

    always_ff @(posedge clk)
    begin
        if (wb_ex && addr_err)
            badv_q <= (wb_ecode == ADE) ? wb_pc : wb_vaddr;
        else if (csr_we && csr_num == BADV)
            badv_q <= badv_wr;
    end

    always_ff @(posedge clk)
    begin
        if (csr_we && csr_num == EENTRY)
            eentry_va <= eentry_wr[CSR_DATA_W-1:EENTRY_LSB];
    end

    always_ff @(posedge clk)
    begin
        if (csr_we && is_save)
            save_q[csr_num[1:0]] <= save_wr;
    end

    always_comb
    begin
        case (csr_num)
            CRMD:   rvalue = crmd;
            PRMD:   rvalue = prmd;
            ERA:    rvalue = era_q;
            BADV:   rvalue = badv_q;
            EENTRY: rvalue = eentry;
            SAVE0, SAVE1, SAVE2, SAVE3:
                rvalue = save_q[csr_num[1:0]];
            default:
                rvalue = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/csr_interrupt.sv
`timescale 1ns/1ns
`default_nettype none

module csr_interrupt
    import csr_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic [CSR_NUM_W-1:0]  csr_num,
    input  wire logic                  csr_we,
    input  wire logic [CSR_DATA_W-1:0] csr_wmask,
    input  wire logic [CSR_DATA_W-1:0] csr_wvalue,
    input  wire logic                  wb_ex,
    input  wire logic [ECODE_W-1:0]    wb_ecode,
    input  wire logic [ESUBCODE_W-1:0] wb_esubcode,
    input  wire logic [HW_INT_W-1:0]   hw_int_in,
    input  wire logic                  ipi_int_in,
    input  wire logic                  timer_int,
    input  wire logic                  crmd_ie,
    output logic      [CSR_DATA_W-1:0] rvalue,
    output logic                       has_int
);

    logic [INT_W-1:0]      ecfg_lie;
    logic [SW_INT_W-1:0]   sw_int;
    logic [HW_INT_W-1:0]   hw_int_q;
    logic                  ipi_int_q;
    logic [ECODE_W-1:0]    estat_ecode;
    logic [ESUBCODE_W-1:0] estat_esubcode;
    logic [INT_W-1:0]      estat_is;
    logic [CSR_DATA_W-1:0] ecfg;
    logic [CSR_DATA_W-1:0] estat;
    logic [CSR_DATA_W-1:0] ecfg_wr;
    logic [CSR_DATA_W-1:0] estat_wr;

    assign ecfg     = {{(CSR_DATA_W-INT_W){1'b0}}, ecfg_lie};
    assign ecfg_wr  = masked_write(ecfg, csr_wmask, csr_wvalue);
    assign estat_wr = masked_write(estat, csr_wmask, csr_wvalue);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ecfg_lie <= '0;
        end
        else if (csr_we && csr_num == ECFG)
        begin
            ecfg_lie               <= ecfg_wr[INT_W-1:0];
            ecfg_lie[INT_RSVD_BIT] <= 1'b0;
        end
    end

    // interrupt lines are registered, one cycle behind the pins
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sw_int         <= '0;
            hw_int_q       <= '0;
            ipi_int_q      <= 1'b0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end
        else
        begin
            if (csr_we && csr_num == ESTAT)
                sw_int <= estat_wr[SW_INT_W-1:0];
            hw_int_q  <= hw_int_in;
            ipi_int_q <= ipi_int_in;
            if (wb_ex)
            begin
                estat_ecode    <= wb_ecode;
                estat_esubcode <= wb_esubcode;
            end
        end
    end

    always_comb
    begin
        estat_is                                = '0;
        estat_is[SW_INT_W-1:0]                  = sw_int;
        estat_is[HW_INT_LSB +: HW_INT_W]        = hw_int_q;
        estat_is[TIMER_INT_BIT]                 = timer_int;
        estat_is[IPI_INT_BIT]                   = ipi_int_q;
        estat                                   = '0;
        estat[INT_W-1:0]                        = estat_is;
        estat[ESTAT_ECODE_LSB +: ECODE_W]       = estat_ecode;
        estat[ESTAT_ESUBCODE_LSB +: ESUBCODE_W] = estat_esubcode;
    end

    // ipi is left out of the pending check
    assign has_int = (|(estat_is[TIMER_INT_BIT:0] & ecfg_lie[TIMER_INT_BIT:0])) && crmd_ie;

    always_comb
    begin
        case (csr_num)
            ECFG:    rvalue = ecfg;
            ESTAT:   rvalue = estat;
            default: rvalue = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/csr_timer.sv
`timescale 1ns/1ns
`default_nettype none

module csr_timer
    import csr_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic [CSR_NUM_W-1:0]  csr_num,
    input  wire logic                  csr_we,
    input  wire logic [CSR_DATA_W-1:0] csr_wmask,
    input  wire logic [CSR_DATA_W-1:0] csr_wvalue,
    input  wire logic [CSR_DATA_W-1:0] coreid_in,
    output logic      [CSR_DATA_W-1:0] rvalue,
    output logic                       timer_int
);

    logic [CSR_DATA_W-1:0] tid;
    logic [CSR_DATA_W-1:0] tcfg;
    logic [CSR_DATA_W-1:0] timer_cnt;
    logic [CSR_DATA_W-1:0] tid_wr;
    logic [CSR_DATA_W-1:0] tcfg_wr;
    logic [CSR_DATA_W-1:0] reload_value;
    logic                  tcfg_write;
    logic                  ticlr_clear;
    logic                  expire;

    assign tid_wr  = masked_write(tid, csr_wmask, csr_wvalue);
    assign tcfg_wr = masked_write(tcfg, csr_wmask, csr_wvalue);

    assign tcfg_write  = csr_we && (csr_num == TCFG);
    assign ticlr_clear = csr_we && (csr_num == TICLR)
                         && csr_wmask[TICLR_CLR_BIT] && csr_wvalue[TICLR_CLR_BIT];

    // initval x4
    assign reload_value = {tcfg[CSR_DATA_W-1:TCFG_INITVAL_LSB], {TCFG_INITVAL_LSB{1'b0}}};
    assign expire       = tcfg[TCFG_EN_BIT] && (timer_cnt == '0);

    always_ff @(posedge clk)
    begin
        if (reset)
            tid <= coreid_in;
        else if (csr_we && csr_num == TID)
            tid <= tid_wr;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            tcfg <= '0;
        else if (tcfg_write)
            tcfg <= tcfg_wr;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            timer_cnt <= TIMER_IDLE;
        end
        else if (tcfg_write && tcfg_wr[TCFG_EN_BIT])
        begin
            timer_cnt <= {tcfg_wr[CSR_DATA_W-1:TCFG_INITVAL_LSB], {TCFG_INITVAL_LSB{1'b0}}};
        end
        else if (tcfg[TCFG_EN_BIT] && timer_cnt != TIMER_IDLE)
        begin
            if (timer_cnt == '0)
                timer_cnt <= tcfg[TCFG_PERIODIC_BIT] ? reload_value : TIMER_IDLE;
            else
                timer_cnt <= timer_cnt - 1'b1;
        end
    end

    // set beats clear
    always_ff @(posedge clk)
    begin
        if (reset)
            timer_int <= 1'b0;
        else if (expire)
            timer_int <= 1'b1;
        else if (ticlr_clear)
            timer_int <= 1'b0;
    end

    always_comb
    begin
        case (csr_num)
            TID:     rvalue = tid;
            TCFG:    rvalue = tcfg;
            TVAL:    rvalue = timer_cnt;
            default: rvalue = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/csr_file.sv
`timescale 1ns/1ns
`default_nettype none

module csr_file
    import csr_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  csr_re,
    input  wire logic [CSR_NUM_W-1:0]  csr_num,
    input  wire logic                  csr_we,
    input  wire logic [CSR_DATA_W-1:0] csr_wmask,
    input  wire logic [CSR_DATA_W-1:0] csr_wvalue,
    input  wire logic                  wb_ex,
    input  wire logic [ECODE_W-1:0]    wb_ecode,
    input  wire logic [ESUBCODE_W-1:0] wb_esubcode,
    input  wire logic [CSR_DATA_W-1:0] wb_pc,
    input  wire logic [CSR_DATA_W-1:0] wb_vaddr,
    input  wire logic                  ertn_flush,
    input  wire logic [HW_INT_W-1:0]   hw_int_in,
    input  wire logic                  ipi_int_in,
    input  wire logic [CSR_DATA_W-1:0] coreid_in,
    output logic      [CSR_DATA_W-1:0] csr_rvalue,
    output logic      [CSR_DATA_W-1:0] csr_eentry,
    output logic      [CSR_DATA_W-1:0] csr_crmd,
    output logic                       has_int
);

    logic [CSR_DATA_W-1:0] exc_rvalue;
    logic [CSR_DATA_W-1:0] int_rvalue;
    logic [CSR_DATA_W-1:0] tmr_rvalue;
    logic                  crmd_ie;
    logic                  timer_int;

    csr_exception_regs u_exception_regs (
        .clk         (clk),
        .reset       (reset),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .ertn_flush  (ertn_flush),
        .rvalue      (exc_rvalue),
        .crmd        (csr_crmd),
        .eentry      (csr_eentry),
        .crmd_ie     (crmd_ie)
    );

    csr_interrupt u_interrupt (
        .clk         (clk),
        .reset       (reset),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .timer_int   (timer_int),
        .crmd_ie     (crmd_ie),
        .rvalue      (int_rvalue),
        .has_int     (has_int)
    );

    csr_timer u_timer (
        .clk        (clk),
        .reset      (reset),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .coreid_in  (coreid_in),
        .rvalue     (tmr_rvalue),
        .timer_int  (timer_int)
    );

    // each block returns zero for numbers it does not own
    assign csr_rvalue = (exc_rvalue | int_rvalue | tmr_rvalue) & {CSR_DATA_W{csr_re}};

endmodule

`default_nettype wire

// File: include/tb_csr_tasks.svh
`ifndef TB_CSR_TASKS_SVH
`define TB_CSR_TASKS_SVH

// every task starts and ends just after a rising edge
task automatic write_csr(input logic [CSR_NUM_W-1:0] num,
                         input logic [CSR_DATA_W-1:0] mask,
                         input logic [CSR_DATA_W-1:0] value);
    csr_we     <= 1'b1;
    csr_num    <= num;
    csr_wmask  <= mask;
    csr_wvalue <= value;
    @(posedge clk);
    csr_we <= 1'b0;
endtask

task automatic read_csr(input logic [CSR_NUM_W-1:0] num, input logic re,
                        output logic [CSR_DATA_W-1:0] value);
    csr_num <= num;
    csr_re  <= re;
    @(negedge clk);
    value        = csr_rvalue;
    seen_crmd    = csr_crmd;
    seen_eentry  = csr_eentry;
    seen_has_int = has_int;
    @(posedge clk);
endtask

task automatic expect_equal(input string label, input logic [CSR_DATA_W-1:0] expected,
                            input logic [CSR_DATA_W-1:0] actual);
    check_count++;
    assert (actual === expected)
    else
    begin
        error_count++;
        $display("Fail %s %s: expected %08h, actual %08h", current_test, label, expected, actual);
    end
endtask

task automatic raise_exception(input logic [ECODE_W-1:0] ecode,
                               input logic [ESUBCODE_W-1:0] esubcode,
                               input logic [CSR_DATA_W-1:0] pc,
                               input logic [CSR_DATA_W-1:0] vaddr);
    wb_ex       <= 1'b1;
    wb_ecode    <= ecode;
    wb_esubcode <= esubcode;
    wb_pc       <= pc;
    wb_vaddr    <= vaddr;
    @(posedge clk);
    wb_ex <= 1'b0;
endtask

task automatic return_from_exception();
    ertn_flush <= 1'b1;
    @(posedge clk);
    ertn_flush <= 1'b0;
endtask

task automatic wait_tval_zero();
    logic [CSR_DATA_W-1:0] value;
    int                    cycles;
    cycles = 0;
    read_csr(TVAL, 1'b1, value);
    while (value != '0 && cycles < TIMEOUT_CYCLES)
    begin
        read_csr(TVAL, 1'b1, value);
        cycles++;
    end
    if (value != '0)
    begin
        timeout_count++;
        $display("Timeout in %s: the timer never counted down to zero", current_test);
    end
endtask

// waits for any line above the software bits, then checks where it landed
task automatic wait_hw_lines(input logic [HW_INT_W-1:0] expected);
    logic [CSR_DATA_W-1:0] value;
    int                    cycles;
    cycles = 0;
    read_csr(ESTAT, 1'b1, value);
    while ((value & 32'h0000_1ffc) == '0 && cycles < TIMEOUT_CYCLES)
    begin
        read_csr(ESTAT, 1'b1, value);
        cycles++;
    end
    if ((value & 32'h0000_1ffc) == '0)
    begin
        timeout_count++;
        $display("Timeout in %s: no hardware line ever showed up in estat", current_test);
    end
    else
    begin
        expect_equal("estat hardware lines", 32'(expected) << 2, value & 32'h0000_1ffc);
    end
endtask

task automatic reset_values();
    logic [CSR_DATA_W-1:0] actual;
    current_test = "reset_values";
    read_csr(CRMD, 1'b1, actual);
    expect_equal("crmd", 32'h0000_0008, actual);
    expect_equal("has_int", 32'h0, 32'(seen_has_int));
    read_csr(TVAL, 1'b1, actual);
    expect_equal("tval", 32'hffff_ffff, actual);
    read_csr(TID, 1'b1, actual);
    expect_equal("tid", COREID, actual);
    read_csr(ECFG, 1'b1, actual);
    expect_equal("ecfg", 32'h0, actual);
    // read enable low hides every register
    read_csr(CRMD, 1'b0, actual);
    expect_equal("gated crmd", 32'h0, actual);
    read_csr(TID, 1'b0, actual);
    expect_equal("gated tid", 32'h0, actual);
    read_csr(TVAL, 1'b0, actual);
    expect_equal("gated tval", 32'h0, actual);
endtask

task automatic masked_register_writes();
    logic [CSR_NUM_W-1:0]  regs [8];
    logic [CSR_DATA_W-1:0] fields;
    logic [CSR_DATA_W-1:0] base;
    logic [CSR_DATA_W-1:0] mask;
    logic [CSR_DATA_W-1:0] value;
    logic [CSR_DATA_W-1:0] expected;
    logic [CSR_DATA_W-1:0] actual;
    current_test = "masked_register_writes";
    regs = '{SAVE0, SAVE1, SAVE2, SAVE3, ERA, PRMD, CRMD, EENTRY};
    for (int i = 0; i < 8; i++)
    begin
        case (regs[i])
            PRMD:    fields = PRMD_FIELDS;
            CRMD:    fields = CRMD_FIELDS;
            EENTRY:  fields = EENTRY_FIELDS;
            default: fields = '1;
        endcase
        // known starting value, then a partial update
        base = $urandom() & fields;
        write_csr(regs[i], '1, base);
        mask     = $urandom();
        value    = $urandom();
        expected = ((mask & value) | (~mask & base)) & fields;
        write_csr(regs[i], mask, value);
        read_csr(regs[i], 1'b1, actual);
        expect_equal($sformatf("csr 0x%0h", regs[i]), expected, actual);
        if (regs[i] == CRMD)
            expect_equal("csr_crmd port", expected, seen_crmd);
        if (regs[i] == EENTRY)
            expect_equal("csr_eentry port", expected, seen_eentry);
    end
endtask

task automatic exception_entry_return();
    logic [CSR_DATA_W-1:0] pc;
    logic [CSR_DATA_W-1:0] pc2;
    logic [CSR_DATA_W-1:0] vaddr;
    logic [CSR_DATA_W-1:0] actual;
    current_test = "exception_entry_return";
    pc    = $urandom() & 32'hffff_fffc;
    pc2   = $urandom() & 32'hffff_fffc;
    vaddr = $urandom();
    // da=1, ie=1, plv=3
    write_csr(CRMD, '1, 32'h0000_000f);
    raise_exception(ALE, '0, pc, vaddr);
    read_csr(CRMD, 1'b1, actual);
    expect_equal("crmd after entry", 32'h0000_0008, actual);
    read_csr(PRMD, 1'b1, actual);
    expect_equal("prmd after entry", 32'h0000_0007, actual);
    read_csr(ERA, 1'b1, actual);
    expect_equal("era", pc, actual);
    read_csr(BADV, 1'b1, actual);
    expect_equal("badv for ALE", vaddr, actual);
    read_csr(ESTAT, 1'b1, actual);
    expect_equal("estat ecode ALE", 32'(ALE), (actual >> ECODE_POS) & 32'h3f);
    return_from_exception();
    read_csr(CRMD, 1'b1, actual);
    expect_equal("crmd after return", 32'h0000_000f, actual);

    raise_exception(ADE, '0, pc2, vaddr);
    read_csr(BADV, 1'b1, actual);
    expect_equal("badv for ADE", pc2, actual);
    read_csr(ERA, 1'b1, actual);
    expect_equal("era for ADE", pc2, actual);
    // no address error, badv holds
    raise_exception(BRK, '0, pc, ~vaddr);
    read_csr(BADV, 1'b1, actual);
    expect_equal("badv after BRK", pc2, actual);
    read_csr(ESTAT, 1'b1, actual);
    expect_equal("estat ecode BRK", 32'(BRK), (actual >> ECODE_POS) & 32'h3f);
    return_from_exception();
endtask

task automatic interrupt_pending();
    logic [CSR_DATA_W-1:0] actual;
    current_test = "interrupt_pending";
    write_csr(CRMD, 32'h4, 32'h4);
    write_csr(ECFG, '1, 32'h1);
    write_csr(ESTAT, 32'h3, 32'h1);
    read_csr(ESTAT, 1'b1, actual);
    expect_equal("estat software bits", 32'h1, actual & 32'h3);
    expect_equal("has_int software", 32'h1, 32'(seen_has_int));

    // line 2 lands in estat bit 4
    hw_int_in <= 8'h04;
    wait_hw_lines(8'h04);
    write_csr(ESTAT, 32'h3, 32'h0);
    read_csr(ECFG, 1'b1, actual);
    expect_equal("has_int line masked", 32'h0, 32'(seen_has_int));
    write_csr(ECFG, '1, 32'h10);
    read_csr(ECFG, 1'b1, actual);
    expect_equal("has_int line enabled", 32'h1, 32'(seen_has_int));
    write_csr(ECFG, '1, 32'h0);
    read_csr(ECFG, 1'b1, actual);
    expect_equal("has_int lie cleared", 32'h0, 32'(seen_has_int));
    write_csr(ECFG, '1, 32'h10);
    write_csr(CRMD, 32'h4, 32'h0);
    read_csr(CRMD, 1'b1, actual);
    expect_equal("has_int ie cleared", 32'h0, 32'(seen_has_int));
    hw_int_in <= 8'h00;
    write_csr(ECFG, '1, 32'h0);
endtask

task automatic oneshot_timer();
    int unsigned           n;
    logic [CSR_DATA_W-1:0] actual;
    current_test = "oneshot_timer";
    n = ($urandom() % 8) + 1;
    write_csr(ECFG, '1, 32'h800);
    write_csr(CRMD, 32'h4, 32'h4);
    write_csr(TCFG, '1, (n << 2) | 32'h1);
    read_csr(TVAL, 1'b1, actual);
    expect_equal("tval after load", 32'(n * 4), actual);
    expect_equal("has_int before expiry", 32'h0, 32'(seen_has_int));
    wait_tval_zero();
    read_csr(ESTAT, 1'b1, actual);
    expect_equal("estat timer bit", 32'h1, (actual >> 11) & 32'h1);
    expect_equal("has_int after expiry", 32'h1, 32'(seen_has_int));
    for (int i = 0; i < 3; i++)
    begin
        read_csr(TVAL, 1'b1, actual);
        expect_equal("tval stopped", 32'hffff_ffff, actual);
    end
    write_csr(TICLR, 32'h1, 32'h1);
    read_csr(ESTAT, 1'b1, actual);
    expect_equal("estat timer bit cleared", 32'h0, (actual >> 11) & 32'h1);
    expect_equal("has_int after clear", 32'h0, 32'(seen_has_int));
    read_csr(TICLR, 1'b1, actual);
    expect_equal("ticlr", 32'h0, actual);
endtask

task automatic periodic_timer();
    int unsigned           n;
    logic [CSR_DATA_W-1:0] actual;
    current_test = "periodic_timer";
    n = ($urandom() % 8) + 1;
    write_csr(TCFG, '1, (n << 2) | 32'h3);
    read_csr(TVAL, 1'b1, actual);
    expect_equal("tval after load", 32'(n * 4), actual);
    wait_tval_zero();
    read_csr(TVAL, 1'b1, actual);
    expect_equal("tval reloaded", 32'(n * 4), actual);
    read_csr(ESTAT, 1'b1, actual);
    expect_equal("estat timer bit first", 32'h1, (actual >> 11) & 32'h1);
    write_csr(TICLR, 32'h1, 32'h1);
    read_csr(ESTAT, 1'b1, actual);
    expect_equal("estat timer bit cleared", 32'h0, (actual >> 11) & 32'h1);
    wait_tval_zero();
    read_csr(ESTAT, 1'b1, actual);
    expect_equal("estat timer bit again", 32'h1, (actual >> 11) & 32'h1);
    write_csr(TCFG, '1, 32'h0);
    write_csr(TICLR, 32'h1, 32'h1);
endtask

`endif

// File: tests/tb_csr.sv
`timescale 1ns/1ns
`default_nettype none

module tb_csr
    import csr_pkg::*;
();

    localparam logic [CSR_DATA_W-1:0] COREID        = 32'h0000_0005;
    localparam logic [CSR_DATA_W-1:0] CRMD_FIELDS   = 32'h0000_01ff;
    localparam logic [CSR_DATA_W-1:0] PRMD_FIELDS   = 32'h0000_0007;
    localparam logic [CSR_DATA_W-1:0] EENTRY_FIELDS = 32'hffff_ffc0;
    localparam int                    ECODE_POS      = 16;
    localparam int                    TIMEOUT_CYCLES = 200;

    logic                  clk;
    logic                  reset;
    logic                  csr_re;
    logic [CSR_NUM_W-1:0]  csr_num;
    logic                  csr_we;
    logic [CSR_DATA_W-1:0] csr_wmask;
    logic [CSR_DATA_W-1:0] csr_wvalue;
    logic                  wb_ex;
    logic [ECODE_W-1:0]    wb_ecode;
    logic [ESUBCODE_W-1:0] wb_esubcode;
    logic [CSR_DATA_W-1:0] wb_pc;
    logic [CSR_DATA_W-1:0] wb_vaddr;
    logic                  ertn_flush;
    logic [HW_INT_W-1:0]   hw_int_in;
    logic                  ipi_int_in;
    logic [CSR_DATA_W-1:0] coreid_in;
    logic [CSR_DATA_W-1:0] csr_rvalue;
    logic [CSR_DATA_W-1:0] csr_eentry;
    logic [CSR_DATA_W-1:0] csr_crmd;
    logic                  has_int;

    int    error_count;
    int    timeout_count;
    int    check_count;
    string current_test;

    // outputs captured together with the last read
    logic [CSR_DATA_W-1:0] seen_crmd;
    logic [CSR_DATA_W-1:0] seen_eentry;
    logic                  seen_has_int;

    csr_file uut (
        .clk         (clk),
        .reset       (reset),
        .csr_re      (csr_re),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .ertn_flush  (ertn_flush),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .coreid_in   (coreid_in),
        .csr_rvalue  (csr_rvalue),
        .csr_eentry  (csr_eentry),
        .csr_crmd    (csr_crmd),
        .has_int     (has_int)
    );

    always #5 clk = ~clk;

    `include "tb_csr_tasks.svh"

    initial
    begin
        void'($urandom(65));
        error_count   = 0;
        timeout_count = 0;
        check_count   = 0;
        current_test  = "setup";
        clk           = 1'b0;
        reset         = 1'b1;
        csr_re        = 1'b0;
        csr_num       = '0;
        csr_we        = 1'b0;
        csr_wmask     = '0;
        csr_wvalue    = '0;
        wb_ex         = 1'b0;
        wb_ecode      = '0;
        wb_esubcode   = '0;
        wb_pc         = '0;
        wb_vaddr      = '0;
        ertn_flush    = 1'b0;
        hw_int_in     = '0;
        ipi_int_in    = 1'b0;
        coreid_in     = COREID;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        reset_values();
        masked_register_writes();
        exception_entry_return();
        interrupt_pending();
        oneshot_timer();
        periodic_timer();

        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
logic/csr_pkg.sv
logic/csr_exception_regs.sv
logic/csr_interrupt.sv
logic/csr_timer.sv
logic/csr_file.sv
tests/tb_csr.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_csr
FILELIST = filelist.f
OBJ_DIR  = obj_dir

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf $(OBJ_DIR)
